/* src.f */
+incdir+source
source/roce_tx_pkg.sv
source/roce_stream_if.sv
source/roce_header_framer.sv
source/roce_icrc_appender.sv
source/roce_tx_top.sv
verification/roce_tx_sva.sv
verification/roce_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the RoCE transmitter testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module roce_tx_tb -o roce_tx_sim \
    && ./obj_dir/roce_tx_sim | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation FAILED"; exit 1; }

/* verification/roce_tx_tb.sv */
// Testbench for the RoCE write-request transmitter against a reference frame model
`timescale 1ns/1ps
`include "roce_tx_settings.svh"

module roce_tx_tb;

    localparam int                   TIMEOUT_CYCLES = 3000;
    localparam roce_tx_pkg::opcode_t OPC   = 8'h0A;
    localparam roce_tx_pkg::pkey_t   PKEY  = 16'hFFFF;
    localparam roce_tx_pkg::vaddr_t  VADDR = 64'h0000_1234_5678_9ABC;
    localparam roce_tx_pkg::rkey_t   RKEY  = 32'h1357_2468;

    logic                  clk, resetn, hdr_valid, hdr_ready, ack_req;
    roce_tx_pkg::opcode_t  opcode;
    roce_tx_pkg::pkey_t    p_key;
    roce_tx_pkg::qp_t      dest_qp;
    roce_tx_pkg::psn_t     psn;
    roce_tx_pkg::vaddr_t   v_addr;
    roce_tx_pkg::rkey_t    r_key;
    roce_tx_pkg::dma_len_t dma_length;
    roce_tx_pkg::word_t    s_data, m_data;
    logic                  s_valid, s_ready, s_last, m_valid, m_ready, m_last;
    logic                  error_early_end;

    // reference request, payload, expected and collected frames
    roce_tx_pkg::psn_t     req_psn;
    roce_tx_pkg::qp_t      req_qp;
    roce_tx_pkg::dma_len_t req_len;
    roce_tx_pkg::word_t    pay_q[$], exp_data[$], got_data[$];
    logic                  exp_last[$], got_last[$];
    int                    cycles, frames_done, err_cycles, errors, tests_run, tests_failed;
    int                    got_base, frame_base, err_base, errors_base;
    logic                  rand_ready;
    integer                seed, rnd;

    roce_tx_top dut (.*);

    always #5 clk = ~clk;

    // output backpressure, random only while enabled
    initial begin
        seed = 36;
        m_ready <= 1'b1;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            m_ready <= rand_ready ? rnd[0] : 1'b1;
        end
    end

    // ====================
    // monitor and timeout
    // ====================
    always @(posedge clk) begin
        cycles++;
        if (resetn && m_valid && m_ready) begin
            got_data.push_back(m_data);
            got_last.push_back(m_last);
            if (m_last) begin
                frames_done++;
            end
        end
        if (resetn && error_early_end) begin
            err_cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped: no end of tests after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input roce_tx_pkg::word_t got,
                              input roce_tx_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ====================
    // reference model
    // ====================
    // header words, payload, then the ICRC with the reserved byte as FF
    task automatic build_expected();
        roce_tx_pkg::word_t words[$];
        roce_tx_pkg::word_t w;
        roce_tx_pkg::crc_t  crc;
        logic [7:0]         byte_v;
        crc = `ROCE_CRC_INIT;
        words = '{{OPC, 8'h00, PKEY}, {8'h00, req_qp}, {1'b1, 7'd0, req_psn},
                  VADDR[63:32], VADDR[31:0], RKEY, req_len};
        foreach (pay_q[i]) begin
            words.push_back(pay_q[i]);
        end
        foreach (words[k]) begin
            w = words[k];
            for (int b = 0; b < 4; b++) begin
                byte_v = w[31-8*b -: 8];
                if (k == `ROCE_RESV_WORD && b == 0) begin
                    byte_v = 8'hFF;
                end
                crc = roce_tx_pkg::crc32_byte(crc, byte_v);
            end
            exp_data.push_back(w);
            exp_last.push_back(1'b0);
        end
        crc = ~crc;
        exp_data.push_back({crc[7:0], crc[15:8], crc[23:16], crc[31:24]});
        exp_last.push_back(1'b1);
    endtask

    task automatic load_request(input roce_tx_pkg::psn_t p, input roce_tx_pkg::qp_t q,
                                input roce_tx_pkg::dma_len_t len, input int n);
        req_psn = p;
        req_qp  = q;
        req_len = len;
        pay_q.delete();
        for (int i = 0; i < n; i++) begin
            pay_q.push_back({p[7:0], 8'(i), 16'h5AC3});
        end
        build_expected();
    endtask

    task automatic send_request();
        @(posedge clk);
        hdr_valid  <= 1'b1;
        psn        <= req_psn;
        dest_qp    <= req_qp;
        dma_length <= req_len;
        do begin
            @(posedge clk);
        end while (!hdr_ready);
        hdr_valid <= 1'b0;
    endtask

    task automatic send_payload(input roce_tx_pkg::word_t words[$]);
        foreach (words[i]) begin
            s_data  <= words[i];
            s_valid <= 1'b1;
            s_last  <= (i == words.size() - 1);
            do begin
                @(posedge clk);
            end while (!s_ready);
        end
        s_valid <= 1'b0;
        s_last  <= 1'b0;
    endtask

    task automatic wait_frames(input int count);
        do begin
            @(negedge clk);
        end while (frames_done - frame_base < count);
        @(posedge clk);
    endtask

    task automatic start_test();
        exp_data.delete();
        exp_last.delete();
        got_base    = got_data.size();
        frame_base  = frames_done;
        err_base    = err_cycles;
        errors_base = errors;
    endtask

    task automatic compare_frames(input logic exp_err);
        if (got_data.size() - got_base != exp_data.size()) begin
            errors++;
            $display("frame length wrong: %0d words came out, %0d expected",
                     got_data.size() - got_base, exp_data.size());
        end else begin
            foreach (exp_data[i]) begin
                check_word("m_data", got_data[got_base + i], exp_data[i]);
                check_flag("m_last", got_last[got_base + i], exp_last[i]);
            end
        end
        check_flag("error_early_end", err_cycles != err_base, exp_err);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - errors_base);
        end
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_values();
        start_test();
        @(posedge clk);
        check_flag("hdr_ready", hdr_ready, 1'b1);
        check_flag("m_valid", m_valid, 1'b0);
        check_flag("s_ready", s_ready, 1'b0);
        check_flag("error_early_end", error_early_end, 1'b0);
        report_test("reset values");
    endtask

    task automatic test_single_frame();
        start_test();
        load_request(24'h000100, 24'h000011, 32'd12, 3);
        send_request();
        send_payload(pay_q);
        wait_frames(1);
        compare_frames(1'b0);
        report_test("single frame");
    endtask

    task automatic test_backpressure();
        start_test();
        load_request(24'h0ABCDE, 24'h000222, 32'd24, 6);
        @(negedge clk);
        rand_ready = 1'b1;
        send_request();
        send_payload(pay_q);
        wait_frames(1);
        @(negedge clk);
        rand_ready = 1'b0;
        compare_frames(1'b0);
        report_test("random backpressure");
    endtask

    task automatic test_early_end();
        start_test();
        load_request(24'h000300, 24'h000033, 32'd20, 2);
        send_request();
        send_payload(pay_q);
        wait_frames(1);
        compare_frames(1'b1);
        report_test("early end");
    endtask

    // second request is offered before the first payload starts
    task automatic test_back_to_back();
        roce_tx_pkg::word_t first_pay[$];
        start_test();
        load_request(24'h000400, 24'h000044, 32'd8, 2);
        send_request();
        @(posedge clk);
        check_flag("hdr_ready", hdr_ready, 1'b0);
        first_pay = pay_q;
        load_request(24'h000401, 24'h000055, 32'd16, 4);
        fork
            send_request();
            send_payload(first_pay);
        join
        send_payload(pay_q);
        wait_frames(2);
        compare_frames(1'b0);
        report_test("back to back");
    endtask

    initial begin
        clk        = 1'b0;
        rand_ready = 1'b0;
        resetn     <= 1'b0;
        hdr_valid  <= 1'b0;
        opcode     <= OPC;
        p_key      <= PKEY;
        dest_qp    <= '0;
        psn        <= '0;
        ack_req    <= 1'b1;
        v_addr     <= VADDR;
        r_key      <= RKEY;
        dma_length <= '0;
        s_data     <= '0;
        s_valid    <= 1'b0;
        s_last     <= 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        test_reset_values();
        test_single_frame();
        test_backpressure();
        test_early_end();
        test_back_to_back();
        $display("tests run %0d, failing %0d, check errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verification/roce_tx_sva.sv */
// Transmitter assertions on output stall stability, request blocking and error pulse width
`timescale 1ns/1ps

module roce_tx_sva (
    input logic               clk,
    input logic               resetn,
    input logic               hdr_valid,
    input logic               hdr_ready,
    input logic               s_valid,
    input logic               s_ready,
    input logic               s_last,
    input roce_tx_pkg::word_t m_data,
    input logic               m_valid,
    input logic               m_ready,
    input logic               m_last,
    input logic               error_early_end
);

    logic in_frame;

    // request taken, payload not yet closed by s_last
    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_frame <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            in_frame <= 1'b1;
        end else if (s_valid && s_ready && s_last) begin
            in_frame <= 1'b0;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!resetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
        else $error("output word changed while stalled");

    a_hdr_blocked: assert property (@(posedge clk) disable iff (!resetn)
        in_frame |-> !hdr_ready)
        else $error("request port open during a frame");

    a_err_pulse: assert property (@(posedge clk) disable iff (!resetn)
        error_early_end |=> !error_early_end)
        else $error("early end error longer than one cycle");

endmodule

bind roce_tx_top roce_tx_sva u_sva (
    .clk             (clk),
    .resetn          (resetn),
    .hdr_valid       (hdr_valid),
    .hdr_ready       (hdr_ready),
    .s_valid         (s_valid),
    .s_ready         (s_ready),
    .s_last          (s_last),
    .m_data          (m_data),
    .m_valid         (m_valid),
    .m_ready         (m_ready),
    .m_last          (m_last),
    .error_early_end (error_early_end)
);

/* source/roce_tx_top.sv */
// RoCE write-request transmitter top joining header framer and ICRC appender
`timescale 1ns/1ps

module roce_tx_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    input  roce_tx_pkg::opcode_t  opcode,
    input  roce_tx_pkg::pkey_t    p_key,
    input  roce_tx_pkg::qp_t      dest_qp,
    input  roce_tx_pkg::psn_t     psn,
    input  logic                  ack_req,
    input  roce_tx_pkg::vaddr_t   v_addr,
    input  roce_tx_pkg::rkey_t    r_key,
    input  roce_tx_pkg::dma_len_t dma_length,
    input  roce_tx_pkg::word_t    s_data,
    input  logic                  s_valid,
    output logic                  s_ready,
    input  logic                  s_last,
    output roce_tx_pkg::word_t    m_data,
    output logic                  m_valid,
    input  logic                  m_ready,
    output logic                  m_last,
    output logic                  error_early_end
);

    // framer to appender
    roce_stream_if frame_stream ();

    roce_header_framer u_framer (
        .clk             (clk),
        .resetn          (resetn),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .opcode          (opcode),
        .p_key           (p_key),
        .dest_qp         (dest_qp),
        .psn             (psn),
        .ack_req         (ack_req),
        .v_addr          (v_addr),
        .r_key           (r_key),
        .dma_length      (dma_length),
        .s_data          (s_data),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .s_last          (s_last),
        .out             (frame_stream.source),
        .error_early_end (error_early_end)
    );

    roce_icrc_appender u_appender (
        .clk     (clk),
        .resetn  (resetn),
        .in      (frame_stream.sink),
        .m_data  (m_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_last  (m_last)
    );

endmodule

/* source/roce_icrc_appender.sv */
// ICRC appender that folds each frame into CRC-32 and adds the ICRC as last word
`timescale 1ns/1ps
`include "roce_tx_settings.svh"

module roce_icrc_appender (
    input  logic               clk,
    input  logic               resetn,
    roce_stream_if.sink        in,
    output roce_tx_pkg::word_t m_data,
    output logic               m_valid,
    input  logic               m_ready,
    output logic               m_last
);

    localparam int         BYTES    = `ROCE_WORD_W / 8;
    localparam logic [2:0] IDX_MAX  = 3'd7;
    localparam logic [2:0] RESV_IDX = 3'(`ROCE_RESV_WORD);

    logic [2:0]         word_idx;
    logic               crc_pend;
    logic               out_free;
    logic               accept;
    logic               valid_q;
    logic               last_q;
    roce_tx_pkg::word_t data_q;
    roce_tx_pkg::word_t masked;
    roce_tx_pkg::word_t crc_word;
    roce_tx_pkg::crc_t  crc_q;
    roce_tx_pkg::crc_t  crc_next;
    roce_tx_pkg::crc_t  crc_final;

    assign out_free = !valid_q || m_ready;
    assign in.ready = out_free && !crc_pend;
    assign accept   = in.valid && in.ready;

    // ====================
    // CRC datapath
    // ====================
    // reserved BTH byte counts as all ones
    always_comb begin
        masked = in.data;
        if (word_idx == RESV_IDX) begin
            masked[`ROCE_WORD_W-1 -: 8] = 8'hFF;
        end
    end

    // msb lane first
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < BYTES; b++) begin
            crc_next = roce_tx_pkg::crc32_byte(crc_next, masked[`ROCE_WORD_W-1-8*b -: 8]);
        end
    end

    assign crc_final = ~crc_q;
    assign crc_word  = {crc_final[7:0], crc_final[15:8], crc_final[23:16], crc_final[31:24]};

    // ====================
    // output stage
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q  <= 1'b0;
            crc_pend <= 1'b0;
            word_idx <= '0;
            crc_q    <= `ROCE_CRC_INIT;
        end else if (accept) begin
            valid_q <= 1'b1;
            crc_q   <= crc_next;
            if (in.last) begin
                crc_pend <= 1'b1;
                word_idx <= '0;
            end else if (word_idx != IDX_MAX) begin
                word_idx <= word_idx + 3'd1;
            end
        end else if (crc_pend && out_free) begin
            // ICRC word goes out, CRC re-armed for the next frame
            valid_q  <= 1'b1;
            crc_pend <= 1'b0;
            crc_q    <= `ROCE_CRC_INIT;
        end else if (m_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in.data;
            last_q <= 1'b0;
        end else if (crc_pend && out_free) begin
            data_q <= crc_word;
            last_q <= 1'b1;
        end
    end

    assign m_data  = data_q;
    assign m_valid = valid_q;
    assign m_last  = last_q;

endmodule

/* source/roce_header_framer.sv */
// Header framer that emits the BTH and RETH words, then forwards the payload
`timescale 1ns/1ps
`include "roce_tx_settings.svh"

module roce_header_framer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    input  roce_tx_pkg::opcode_t  opcode,
    input  roce_tx_pkg::pkey_t    p_key,
    input  roce_tx_pkg::qp_t      dest_qp,
    input  roce_tx_pkg::psn_t     psn,
    input  logic                  ack_req,
    input  roce_tx_pkg::vaddr_t   v_addr,
    input  roce_tx_pkg::rkey_t    r_key,
    input  roce_tx_pkg::dma_len_t dma_length,
    input  roce_tx_pkg::word_t    s_data,
    input  logic                  s_valid,
    output logic                  s_ready,
    input  logic                  s_last,
    roce_stream_if.source         out,
    output logic                  error_early_end
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_PAY  = 2'd2;

    localparam int IDX_W = $clog2(`ROCE_HDR_WORDS);
    localparam logic [IDX_W-1:0] HDR_LAST = IDX_W'(`ROCE_HDR_WORDS - 1);

    logic [1:0]            state;
    logic [IDX_W-1:0]      hdr_idx;
    logic                  hdr_accept;
    logic                  pay_accept;
    roce_tx_pkg::word_t    hdr_word;
    roce_tx_pkg::dma_len_t pay_cnt;
    roce_tx_pkg::dma_len_t pay_cnt_next;

    // captured request
    roce_tx_pkg::opcode_t  opcode_q;
    roce_tx_pkg::pkey_t    p_key_q;
    roce_tx_pkg::qp_t      dest_qp_q;
    roce_tx_pkg::psn_t     psn_q;
    logic                  ack_req_q;
    roce_tx_pkg::vaddr_t   v_addr_q;
    roce_tx_pkg::rkey_t    r_key_q;
    roce_tx_pkg::dma_len_t dma_length_q;

    assign hdr_ready    = (state == ST_IDLE);
    assign hdr_accept   = hdr_valid && hdr_ready;
    assign pay_accept   = (state == ST_PAY) && s_valid && out.ready;
    assign pay_cnt_next = pay_cnt + 32'd1;

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            opcode_q     <= opcode;
            p_key_q      <= p_key;
            dest_qp_q    <= dest_qp;
            psn_q        <= psn;
            ack_req_q    <= ack_req;
            v_addr_q     <= v_addr;
            r_key_q      <= r_key;
            dma_length_q <= dma_length;
        end
    end

    // ====================
    // header words
    // ====================
    always_comb begin
        case (hdr_idx)
            3'd0:    hdr_word = {opcode_q, 8'h00, p_key_q};
            3'd1:    hdr_word = {8'h00, dest_qp_q};
            3'd2:    hdr_word = {ack_req_q, 7'b0000000, psn_q};
            3'd3:    hdr_word = v_addr_q[63:32];
            3'd4:    hdr_word = v_addr_q[31:0];
            3'd5:    hdr_word = r_key_q;
            3'd6:    hdr_word = dma_length_q;
            default: hdr_word = '0;
        endcase
    end

    // payload goes straight through once the header is out
    always_comb begin
        out.valid = 1'b0;
        out.data  = hdr_word;
        out.last  = 1'b0;
        s_ready   = 1'b0;
        case (state)
            ST_HDR: begin
                out.valid = 1'b1;
            end
            ST_PAY: begin
                out.valid = s_valid;
                out.data  = s_data;
                out.last  = s_last;
                s_ready   = out.ready;
            end
            default: begin
            end
        endcase
    end

    // ====================
    // FSM and length check
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state           <= ST_IDLE;
            hdr_idx         <= '0;
            pay_cnt         <= '0;
            error_early_end <= 1'b0;
        end else begin
            error_early_end <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (hdr_accept) begin
                        state   <= ST_HDR;
                        hdr_idx <= '0;
                        pay_cnt <= '0;
                    end
                end
                ST_HDR: begin
                    if (out.ready) begin
                        if (hdr_idx == HDR_LAST) begin
                            state <= ST_PAY;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                ST_PAY: begin
                    if (pay_accept) begin
                        pay_cnt <= pay_cnt_next;
                        if (s_last) begin
                            state <= ST_IDLE;
                            // fewer words than the RETH length promised
                            error_early_end <= (pay_cnt_next < (dma_length_q >> 2));
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/roce_stream_if.sv */
// Word stream with valid/ready handshake and end-of-frame marker
`timescale 1ns/1ps

interface roce_stream_if;

    roce_tx_pkg::word_t data;
    logic               valid;
    logic               ready;
    logic               last;

    modport source (
        output data, valid, last,
        input  ready
    );

    modport sink (
        input  data, valid, last,
        output ready
    );

endinterface

/* source/roce_tx_pkg.sv */
// RoCE transmitter package with header field types and the ICRC byte step
`include "roce_tx_settings.svh"

package roce_tx_pkg;

    // ====================
    // field types
    // ====================
    typedef logic [`ROCE_WORD_W-1:0] word_t;
    typedef logic [7:0]              opcode_t;
    typedef logic [15:0]             pkey_t;
    typedef logic [23:0]             qp_t;
    typedef logic [23:0]             psn_t;
    typedef logic [63:0]             vaddr_t;
    typedef logic [31:0]             rkey_t;
    typedef logic [31:0]             dma_len_t;
    typedef logic [31:0]             crc_t;

    // ====================
    // CRC-32 step
    // ====================
    // one byte, lsb first, reflected polynomial
    function automatic crc_t crc32_byte(input crc_t crc, input logic [7:0] data);
        crc_t c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ `ROCE_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

/* source/roce_tx_settings.svh */
// RoCE transmitter settings for stream width, header size and ICRC constants
`ifndef ROCE_TX_SETTINGS_SVH
`define ROCE_TX_SETTINGS_SVH

// stream word and header size
`define ROCE_WORD_W     32
`define ROCE_HDR_WORDS  7

// reflected CRC-32 for the ICRC
`define ROCE_CRC_POLY   32'hEDB88320
`define ROCE_CRC_INIT   32'hFFFFFFFF
`define ROCE_RESV_WORD  1

`endif
